/* source/csa_bridge_params.svh */
`ifndef CSA_BRIDGE_PARAMS_SVH
`define CSA_BRIDGE_PARAMS_SVH

// stream and host bus word width
`define CSA_DATA_WIDTH 32

// host register address width
`define CSA_REG_ADDR_BITS 10

// input FIFO depth in words
`define CSA_IN_FIFO_DEPTH 16

// record lengths in words
`define CSA_TASK_WORDS 5
`define CSA_RESULT_WORDS 7

// significant bits of key high word
`define CSA_KEY_HI_BITS 16

`endif

/* source/csa_bridge_pkg.sv */
`default_nettype none

`include "csa_bridge_params.svh"

package csa_bridge_pkg;

	// record as it arrives on the input stream, block word first
	typedef struct packed {
		logic [`CSA_DATA_WIDTH-1:0] block;
		logic [`CSA_DATA_WIDTH-1:0] key_lo;
		logic [`CSA_DATA_WIDTH-1:0] key_hi; // low bits only
		logic [`CSA_DATA_WIDTH-1:0] times;
		logic [`CSA_DATA_WIDTH-1:0] start;
	} csa_task_t;

	typedef struct packed {
		csa_task_t task_rec;
		logic [`CSA_DATA_WIDTH-1:0] result_0;
		logic [`CSA_DATA_WIDTH-1:0] result_1;
	} csa_result_t;

	typedef enum logic [`CSA_REG_ADDR_BITS-1:0] {
		REG_CTRL      = 0, // bit 0 fetch enable
		REG_IN_VALID  = 1,
		REG_IN_DATA_0 = 2,
		REG_IN_DATA_1 = 3,
		REG_IN_DATA_2 = 4,
		REG_IN_DATA_3 = 5,
		REG_IN_DATA_4 = 6,
		REG_RESULT_0  = 7,
		REG_RESULT_1  = 8,
		REG_COMMIT    = 9,
		REG_ERROR     = 10
	} csa_reg_e;

	typedef enum logic [1:0] {
		UNPACK_IDLE,
		UNPACK_FETCH,
		UNPACK_HOLD
	} csa_unpack_state_e;

	typedef enum logic {
		PACK_IDLE,
		PACK_SEND
	} csa_pack_state_e;

endpackage

`default_nettype wire

/* source/csa_bridge_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csa_bridge_params.svh"

module csa_bridge_top (
	input  wire                           axi_mm_clk,
	input  wire                           rst_n,

	input  wire                           in_valid_i,
	input  wire  [`CSA_DATA_WIDTH-1:0]    in_data_i,
	output logic                          in_ready_o,

	output logic                          out_valid_o,
	output logic [`CSA_DATA_WIDTH-1:0]    out_data_o,
	input  wire                           out_ready_i,

	input  wire                           host_wen_i,
	input  wire  [`CSA_REG_ADDR_BITS-1:0] host_waddr_i,
	input  wire  [`CSA_DATA_WIDTH-1:0]    host_wdata_i,
	input  wire                           host_ren_i,
	input  wire  [`CSA_REG_ADDR_BITS-1:0] host_raddr_i,
	output logic [`CSA_DATA_WIDTH-1:0]    host_rdata_o
);

	import csa_bridge_pkg::*;

	logic fifo_rd_valid;
	logic [`CSA_DATA_WIDTH-1:0] fifo_rd_data;
	logic fifo_rd_ready;
	logic fetch_en;
	logic task_valid;
	csa_task_t task_rec;
	logic task_ready;
	logic result_valid;
	csa_result_t result_rec;
	logic result_ready;

	csa_word_fifo #(
		.DEPTH(`CSA_IN_FIFO_DEPTH)
	) csa_word_fifo_inst (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wr_valid_i(in_valid_i),
		.wr_data_i(in_data_i),
		.wr_ready_o(in_ready_o),
		.rd_valid_o(fifo_rd_valid),
		.rd_data_o(fifo_rd_data),
		.rd_ready_i(fifo_rd_ready)
	);

	csa_task_unpacker csa_task_unpacker_inst (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.fetch_en_i(fetch_en),
		.word_valid_i(fifo_rd_valid),
		.word_data_i(fifo_rd_data),
		.word_ready_o(fifo_rd_ready),
		.task_valid_o(task_valid),
		.task_o(task_rec),
		.task_ready_i(task_ready)
	);

	csa_mailbox_regs csa_mailbox_regs_inst (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.host_wen_i(host_wen_i),
		.host_waddr_i(host_waddr_i),
		.host_wdata_i(host_wdata_i),
		.host_ren_i(host_ren_i),
		.host_raddr_i(host_raddr_i),
		.host_rdata_o(host_rdata_o),
		.fetch_en_o(fetch_en),
		.task_valid_i(task_valid),
		.task_i(task_rec),
		.task_ready_o(task_ready),
		.result_valid_o(result_valid),
		.result_o(result_rec),
		.result_ready_i(result_ready)
	);

	csa_result_packer csa_result_packer_inst (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.result_valid_i(result_valid),
		.result_i(result_rec),
		.result_ready_o(result_ready),
		.out_valid_o(out_valid_o),
		.out_data_o(out_data_o),
		.out_ready_i(out_ready_i)
	);

endmodule

`default_nettype wire

/* source/csa_mailbox_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csa_bridge_params.svh"

module csa_mailbox_regs (
	input  wire                          axi_mm_clk,
	input  wire                          rst_n,

	input  wire                          host_wen_i,
	input  wire  [`CSA_REG_ADDR_BITS-1:0] host_waddr_i,
	input  wire  [`CSA_DATA_WIDTH-1:0]   host_wdata_i,
	input  wire                          host_ren_i,
	input  wire  [`CSA_REG_ADDR_BITS-1:0] host_raddr_i,
	output logic [`CSA_DATA_WIDTH-1:0]   host_rdata_o,

	output logic                         fetch_en_o,

	input  wire                          task_valid_i,
	input  wire  csa_bridge_pkg::csa_task_t task_i,
	output logic                         task_ready_o,

	output logic                         result_valid_o,
	output csa_bridge_pkg::csa_result_t  result_o,
	input  wire                          result_ready_i
);

	import csa_bridge_pkg::*;

	localparam logic [`CSA_DATA_WIDTH-2:0] PAD = '0;

	logic fetch_en_q;
	logic task_held_q;
	logic error_q;
	logic result_valid_q;
	logic commit_wr;
	logic commit_ok;
	csa_task_t task_q;
	csa_result_t result_q;
	logic [`CSA_DATA_WIDTH-1:0] result_0_q;
	logic [`CSA_DATA_WIDTH-1:0] result_1_q;
	logic [`CSA_DATA_WIDTH-1:0] rdata_mux;

	assign commit_wr = host_wen_i && (host_waddr_i == REG_COMMIT);
	assign commit_ok = commit_wr && task_held_q && result_ready_i; // slot full, packer idle

	assign fetch_en_o     = fetch_en_q;
	assign task_ready_o   = !task_held_q;
	assign result_valid_o = result_valid_q;
	assign result_o       = result_q;

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			fetch_en_q     <= 1'b0;
			task_held_q    <= 1'b0;
			error_q        <= 1'b0;
			result_valid_q <= 1'b0;
		end else begin
			if (host_wen_i && host_waddr_i == REG_CTRL) begin
				fetch_en_q <= host_wdata_i[0];
			end

			if (task_valid_i && task_ready_o) begin
				task_held_q <= 1'b1;
			end

			if (result_valid_q && result_ready_i) begin
				result_valid_q <= 1'b0;
			end

			if (host_wen_i && host_waddr_i == REG_ERROR) begin
				error_q <= 1'b0; // any write clears
			end

			if (commit_ok) begin
				task_held_q    <= 1'b0;
				result_valid_q <= 1'b1;
			end else if (commit_wr) begin
				error_q <= 1'b1;
			end
		end
	end

	// payload registers
	always_ff @(posedge axi_mm_clk) begin
		if (task_valid_i && task_ready_o) begin
			task_q <= task_i;
		end
		if (host_wen_i && host_waddr_i == REG_RESULT_0) begin
			result_0_q <= host_wdata_i;
		end
		if (host_wen_i && host_waddr_i == REG_RESULT_1) begin
			result_1_q <= host_wdata_i;
		end
		if (commit_ok) begin
			result_q <= '{task_rec: task_q, result_0: result_0_q, result_1: result_1_q};
		end
	end

	always_comb begin
		case (host_raddr_i)
			REG_CTRL:      rdata_mux = {PAD, fetch_en_q};
			REG_IN_VALID:  rdata_mux = {PAD, task_held_q};
			REG_IN_DATA_0: rdata_mux = task_q.block;
			REG_IN_DATA_1: rdata_mux = task_q.key_lo;
			REG_IN_DATA_2: rdata_mux = task_q.key_hi;
			REG_IN_DATA_3: rdata_mux = task_q.times;
			REG_IN_DATA_4: rdata_mux = task_q.start;
			REG_RESULT_0:  rdata_mux = result_0_q;
			REG_RESULT_1:  rdata_mux = result_1_q;
			REG_ERROR:     rdata_mux = {PAD, error_q};
			default:       rdata_mux = '0; // commit and unmapped
		endcase
	end

	// one cycle read latency
	always_ff @(posedge axi_mm_clk) begin
		if (host_ren_i) begin
			host_rdata_o <= rdata_mux;
		end
	end

endmodule

`default_nettype wire

/* source/csa_result_packer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csa_bridge_params.svh"

module csa_result_packer (
	input  wire                          axi_mm_clk,
	input  wire                          rst_n,

	input  wire                          result_valid_i,
	input  wire  csa_bridge_pkg::csa_result_t result_i,
	output logic                         result_ready_o,

	output logic                         out_valid_o,
	output logic [`CSA_DATA_WIDTH-1:0]   out_data_o,
	input  wire                          out_ready_i
);

	import csa_bridge_pkg::*;

	localparam int IDX_W = $clog2(`CSA_RESULT_WORDS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`CSA_RESULT_WORDS - 1);

	csa_pack_state_e state_q;
	logic [IDX_W-1:0] idx_q;
	csa_result_t rec_q;

	assign result_ready_o = (state_q == PACK_IDLE);
	assign out_valid_o    = (state_q == PACK_SEND);

	always_comb begin
		case (idx_q)
			0: out_data_o = rec_q.task_rec.block;
			1: out_data_o = rec_q.task_rec.key_lo;
			2: out_data_o = rec_q.task_rec.key_hi;
			3: out_data_o = rec_q.task_rec.times;
			4: out_data_o = rec_q.task_rec.start;
			5: out_data_o = rec_q.result_0;
			default: out_data_o = rec_q.result_1;
		endcase
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state_q <= PACK_IDLE;
			idx_q   <= '0;
		end else begin
			case (state_q)
				PACK_IDLE: begin
					if (result_valid_i) begin
						state_q <= PACK_SEND;
						idx_q   <= '0;
					end
				end
				PACK_SEND: begin
					if (out_ready_i) begin // word held while stalled
						idx_q <= idx_q + 1'b1;
						if (idx_q == LAST_IDX) begin
							state_q <= PACK_IDLE;
						end
					end
				end
				default: state_q <= PACK_IDLE;
			endcase
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (result_valid_i && result_ready_o) begin
			rec_q <= result_i;
		end
	end

endmodule

`default_nettype wire

/* source/csa_task_unpacker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csa_bridge_params.svh"

module csa_task_unpacker (
	input  wire                        axi_mm_clk,
	input  wire                        rst_n,

	input  wire                        fetch_en_i,

	input  wire                        word_valid_i,
	input  wire  [`CSA_DATA_WIDTH-1:0] word_data_i,
	output logic                       word_ready_o,

	output logic                       task_valid_o,
	output csa_bridge_pkg::csa_task_t  task_o,
	input  wire                        task_ready_i
);

	import csa_bridge_pkg::*;

	localparam int IDX_W = $clog2(`CSA_TASK_WORDS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`CSA_TASK_WORDS - 1);
	localparam logic [`CSA_DATA_WIDTH-1:0] KEY_HI_MASK =
		{{(`CSA_DATA_WIDTH - `CSA_KEY_HI_BITS){1'b0}}, {`CSA_KEY_HI_BITS{1'b1}}};

	csa_unpack_state_e state_q;
	logic [IDX_W-1:0] idx_q;
	csa_task_t task_q;

	assign word_ready_o = (state_q == UNPACK_FETCH);
	assign task_valid_o = (state_q == UNPACK_HOLD);
	assign task_o       = task_q;

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state_q <= UNPACK_IDLE;
			idx_q   <= '0;
		end else begin
			case (state_q)
				UNPACK_IDLE: begin
					idx_q <= '0;
					if (fetch_en_i) begin // only checked between records
						state_q <= UNPACK_FETCH;
					end
				end
				UNPACK_FETCH: begin
					if (word_valid_i) begin
						idx_q <= idx_q + 1'b1;
						if (idx_q == LAST_IDX) begin
							state_q <= UNPACK_HOLD;
						end
					end
				end
				UNPACK_HOLD: begin
					if (task_ready_i) begin
						state_q <= UNPACK_IDLE;
					end
				end
				default: state_q <= UNPACK_IDLE;
			endcase
		end
	end

	// field fill, one word per accepted beat
	always_ff @(posedge axi_mm_clk) begin
		if (word_ready_o && word_valid_i) begin
			case (idx_q)
				0: task_q.block  <= word_data_i;
				1: task_q.key_lo <= word_data_i;
				2: task_q.key_hi <= word_data_i & KEY_HI_MASK;
				3: task_q.times  <= word_data_i;
				default: task_q.start <= word_data_i;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/csa_word_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csa_bridge_params.svh"

module csa_word_fifo #(
	parameter int DEPTH = `CSA_IN_FIFO_DEPTH
) (
	input  wire                        axi_mm_clk,
	input  wire                        rst_n,

	input  wire                        wr_valid_i,
	input  wire  [`CSA_DATA_WIDTH-1:0] wr_data_i,
	output logic                       wr_ready_o,

	output logic                       rd_valid_o,
	output logic [`CSA_DATA_WIDTH-1:0] rd_data_o,
	input  wire                        rd_ready_i
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

	logic [`CSA_DATA_WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign wr_ready_o = (count != FULL_CNT);
	assign rd_valid_o = (count != '0);
	assign rd_data_o  = mem[rd_ptr]; // head word, no read latency

	assign push = wr_valid_i && wr_ready_o;
	assign pop  = rd_valid_o && rd_ready_i;

	always_ff @(posedge axi_mm_clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_data_i;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1; // wrap
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // none or both
			endcase
		end
	end

endmodule

`default_nettype wire

/* tb/csa_bridge_tb.sv */
`timescale 1ns/1ns
`include "csa_bridge_params.svh"
`default_nettype none

module csa_bridge_tb;

	import csa_bridge_pkg::*;

	localparam int NUM_ROWS = 5;
	localparam int NUM_WORDS = NUM_ROWS * `CSA_TASK_WORDS;
	localparam int TIMEOUT_CYCLES = 1000;
	localparam int SEED = 52947;

	// raw task words as pushed, key_hi unmasked, plus host results
	typedef struct packed {
		csa_result_t rec;
		logic stall; // random out_ready_i gaps for this record
	} row_t;

	logic axi_mm_clk;
	logic rst_n;
	logic in_valid_i;
	logic [`CSA_DATA_WIDTH-1:0] in_data_i;
	logic in_ready_o;
	logic out_valid_o;
	logic [`CSA_DATA_WIDTH-1:0] out_data_o;
	logic out_ready_i;
	logic host_wen_i;
	logic [`CSA_REG_ADDR_BITS-1:0] host_waddr_i;
	logic [`CSA_DATA_WIDTH-1:0] host_wdata_i;
	logic host_ren_i;
	logic [`CSA_REG_ADDR_BITS-1:0] host_raddr_i;
	logic [`CSA_DATA_WIDTH-1:0] host_rdata_o;

	row_t rows [NUM_ROWS];
	int mismatch_cnt = 0;
	int timeout_cnt = 0;
	int records_done = 0;
	int unsigned rnd_init;

	csa_bridge_top csa_bridge_top_inst (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.in_valid_i(in_valid_i),
		.in_data_i(in_data_i),
		.in_ready_o(in_ready_o),
		.out_valid_o(out_valid_o),
		.out_data_o(out_data_o),
		.out_ready_i(out_ready_i),
		.host_wen_i(host_wen_i),
		.host_waddr_i(host_waddr_i),
		.host_wdata_i(host_wdata_i),
		.host_ren_i(host_ren_i),
		.host_raddr_i(host_raddr_i),
		.host_rdata_o(host_rdata_o)
	);

	initial begin
		axi_mm_clk = 1'b0;
		forever #20 axi_mm_clk = ~axi_mm_clk;
	end

	function automatic logic [`CSA_DATA_WIDTH-1:0] task_field(input csa_task_t t, input int f);
		case (f)
			0: return t.block;
			1: return t.key_lo;
			2: return t.key_hi;
			3: return t.times;
			default: return t.start;
		endcase
	endfunction

	function automatic logic [`CSA_DATA_WIDTH-1:0] stream_word(input int w);
		return task_field(rows[w / `CSA_TASK_WORDS].rec.task_rec, w % `CSA_TASK_WORDS);
	endfunction

	// only the low key bits survive the unpacker
	function automatic csa_result_t expected_record(input row_t row);
		csa_result_t exp_rec;
		logic [`CSA_DATA_WIDTH-1:0] mask;
		mask = '0;
		mask[`CSA_KEY_HI_BITS-1:0] = '1;
		exp_rec = row.rec;
		exp_rec.task_rec.key_hi = row.rec.task_rec.key_hi & mask;
		return exp_rec;
	endfunction

	task automatic check_word(input string name, input logic [`CSA_DATA_WIDTH-1:0] got,
			input logic [`CSA_DATA_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic check_result(input int idx, input csa_result_t got, input csa_result_t exp);
		if (got !== exp) begin
			$display("FAILED out_data_o record %0d: got %h expected %h", idx, got, exp);
			mismatch_cnt++;
		end
	endtask

	// all drivers enter and leave 2 ns after a rising edge
	task automatic host_write(input csa_reg_e addr, input logic [`CSA_DATA_WIDTH-1:0] data);
		host_wen_i   = 1'b1;
		host_waddr_i = addr;
		host_wdata_i = data;
		@(posedge axi_mm_clk);
		#2;
		host_wen_i = 1'b0;
	endtask

	task automatic host_read(input csa_reg_e addr, output logic [`CSA_DATA_WIDTH-1:0] data);
		host_ren_i   = 1'b1;
		host_raddr_i = addr;
		@(posedge axi_mm_clk);
		#2;
		host_ren_i = 1'b0;
		data = host_rdata_o; // registered on that edge
	endtask

	task automatic push_word(input logic [`CSA_DATA_WIDTH-1:0] data);
		int waited;
		waited = 0;
		in_valid_i = 1'b1;
		in_data_i  = data;
		@(negedge axi_mm_clk);
		while (!in_ready_o && waited < TIMEOUT_CYCLES) begin
			@(negedge axi_mm_clk);
			waited++;
		end
		if (!in_ready_o) begin
			$display("timeout: input stream never accepted word %h", data);
			timeout_cnt++;
		end
		@(posedge axi_mm_clk);
		#2;
		in_valid_i = 1'b0;
	endtask

	task automatic push_remaining(input int first);
		for (int w = first; w < NUM_WORDS; w++) begin
			push_word(stream_word(w));
		end
	endtask

	task automatic run_host;
		logic [`CSA_DATA_WIDTH-1:0] rd;
		csa_result_t exp_rec;
		int polls;
		host_write(REG_CTRL, 32'h1);
		for (int r = 0; r < NUM_ROWS; r++) begin
			exp_rec = expected_record(rows[r]);
			polls = 0;
			rd = '0;
			while (rd[0] !== 1'b1 && polls < TIMEOUT_CYCLES) begin
				host_read(REG_IN_VALID, rd);
				polls++;
			end
			if (rd[0] !== 1'b1) begin
				$display("timeout: task %0d never showed up in the register bank", r);
				timeout_cnt++;
			end
			for (int f = 0; f < `CSA_TASK_WORDS; f++) begin
				host_read(csa_reg_e'(REG_IN_DATA_0 + f), rd);
				check_word($sformatf("host_rdata_o IN_DATA_%0d row %0d", f, r), rd,
					task_field(exp_rec.task_rec, f));
			end
			polls = 0;
			while (records_done < r && polls < TIMEOUT_CYCLES) begin // packer must be idle
				@(posedge axi_mm_clk);
				#2;
				polls++;
			end
			if (records_done < r) begin
				$display("timeout: record %0d never finished on the output", r - 1);
				timeout_cnt++;
			end
			host_write(REG_RESULT_0, rows[r].rec.result_0);
			host_write(REG_RESULT_1, rows[r].rec.result_1);
			host_write(REG_COMMIT, 32'h1);
			host_read(REG_ERROR, rd);
			check_word($sformatf("host_rdata_o ERROR after commit %0d", r), rd, '0);
		end
	endtask

	task automatic collect_records;
		logic [`CSA_RESULT_WORDS*`CSA_DATA_WIDTH-1:0] gather;
		csa_result_t got;
		int n_words;
		int idle;
		n_words = 0;
		idle = 0;
		gather = '0;
		while (records_done < NUM_ROWS && idle < TIMEOUT_CYCLES) begin
			if (rows[records_done].stall) begin
				out_ready_i = ($urandom % 3) != 0;
			end else begin
				out_ready_i = 1'b1;
			end
			@(negedge axi_mm_clk);
			if (out_valid_o && out_ready_i) begin
				gather = {gather[(`CSA_RESULT_WORDS-1)*`CSA_DATA_WIDTH-1:0], out_data_o};
				n_words++;
				idle = 0;
				if (n_words == `CSA_RESULT_WORDS) begin
					got = gather;
					check_result(records_done, got, expected_record(rows[records_done]));
					records_done++;
					n_words = 0;
				end
			end else begin
				idle++;
			end
			@(posedge axi_mm_clk);
			#2;
		end
		if (records_done < NUM_ROWS) begin
			$display("timeout: only %0d of %0d records came out", records_done, NUM_ROWS);
			timeout_cnt++;
		end
	endtask

	initial begin
		logic [`CSA_DATA_WIDTH-1:0] rd;
		int extra;
		rows[0] = {32'h0000_0100, 32'ha5a5_0001, 32'hffff_1234, 32'h0000_0040,
			32'h0000_0000, 32'hc0de_0000, 32'hc0de_0001, 1'b0};
		rows[1] = {32'h0000_0101, 32'h3c3c_7e7e, 32'h8001_beef, 32'h0000_0080,
			32'h0000_0007, 32'h0bad_f00d, 32'h1234_5678, 1'b1};
		rows[2] = {32'h0000_0102, 32'h0f0f_0f0f, 32'h0000_00ff, 32'h0000_0001,
			32'h0000_0010, 32'h5555_aaaa, 32'haaaa_5555, 1'b0};
		rows[3] = {32'h0000_0103, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_1000,
			32'h0000_00bc, 32'h0000_0000, 32'hffff_ffff, 1'b1};
		rows[4] = {32'h0000_0104, 32'h1357_9bdf, 32'h2468_ace0, 32'h0000_0020,
			32'h0000_0003, 32'h89ab_cdef, 32'h0123_4567, 1'b1};
		rst_n        = 1'b0;
		in_valid_i   = 1'b0;
		in_data_i    = '0;
		out_ready_i  = 1'b0; // stray output would stay visible
		host_wen_i   = 1'b0;
		host_waddr_i = '0;
		host_wdata_i = '0;
		host_ren_i   = 1'b0;
		host_raddr_i = '0;
		rnd_init = $urandom(SEED);
		repeat (10) @(posedge axi_mm_clk);
		#2;
		rst_n = 1'b1;
		check_flag("in_ready_o", in_ready_o, 1'b1);
		check_flag("out_valid_o", out_valid_o, 1'b0);
		host_read(REG_CTRL, rd);
		check_word("host_rdata_o CTRL", rd, '0);
		host_read(REG_ERROR, rd);
		check_word("host_rdata_o ERROR", rd, '0);
		// commit with nothing held
		host_write(REG_COMMIT, 32'h1);
		host_read(REG_ERROR, rd);
		check_word("host_rdata_o ERROR after empty commit", rd, 32'h1);
		host_write(REG_ERROR, 32'h0);
		host_read(REG_ERROR, rd);
		check_word("host_rdata_o ERROR after clear", rd, '0);
		for (int w = 0; w < `CSA_IN_FIFO_DEPTH; w++) begin
			push_word(stream_word(w));
		end
		@(negedge axi_mm_clk);
		check_flag("in_ready_o with FIFO full", in_ready_o, 1'b0);
		@(posedge axi_mm_clk);
		#2;
		host_read(REG_IN_VALID, rd);
		check_word("host_rdata_o IN_VALID with fetch off", rd, '0);
		fork
			push_remaining(`CSA_IN_FIFO_DEPTH);
			run_host();
			collect_records();
		join
		out_ready_i = 1'b1;
		extra = 0;
		for (int c = 0; c < 20; c++) begin
			@(negedge axi_mm_clk);
			if (out_valid_o) begin
				extra++;
			end
		end
		if (extra != 0) begin
			$display("output stream carried %0d words after the last record", extra);
			mismatch_cnt++;
		end
		$display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
		if (mismatch_cnt == 0 && timeout_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/csa_bridge_pkg.sv
source/csa_word_fifo.sv
source/csa_task_unpacker.sv
source/csa_mailbox_regs.sv
source/csa_result_packer.sv
source/csa_bridge_top.sv
tb/csa_bridge_tb.sv
